// ==== design/fetch_ctrl.sv ====
`timescale 1ns/1ns

module fetch_ctrl (
    // Clock and reset
    input  logic                 i_clk,
    input  logic                 i_rst_n,

    // Levels from outside the front end
    input  logic                 i_fetch_en,
    input  logic                 i_stall,
    input  fetch_pkg::redirect_s i_redirect,

    // Strobes to the stages
    output logic                 o_issue, // F1 sends a new pc
    output logic                 o_load,  // F1 takes the redirect target
    output logic                 o_kill,  // F2 drops the item coming from F1
    output logic                 o_hold   // Everything freezes
);

    import fetch_pkg::*;

    fetch_state_e state_q;
    fetch_state_e state_d;

    logic flush;   // Redirect pulse seen this cycle
    logic running; // Registered state allows issue

    assign flush   = i_redirect.flush;
    assign running = (state_q == RUN);

    // Next state from the enable level only
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_fetch_en) begin
                    state_d = RUN; // First fetch one cycle later
                end
            end
            RUN: begin
                if (!i_fetch_en) begin
                    state_d = HALT; // Still issues on this edge
                end
            end
            HALT: begin
                if (i_fetch_en) begin
                    state_d = RUN; // Resume at next unissued pc
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // State register, frozen while stalled
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
        end else if (!i_stall) begin
            state_q <= state_d;
        end
    end

    // Stall is a pure level, no state of its own
    assign o_hold = i_stall;

    // Flush loads F1 and kills what F1 already holds
    // Stall wins so a held pipe never moves
    assign o_load = flush && !i_stall;
    assign o_kill = flush && !i_stall;

    // Issue in RUN only; on a flush cycle the loaded target is what gets issued
    // Outside RUN a flush just points the pc at the target
    assign o_issue = running && !i_stall;

endmodule : fetch_ctrl

// ==== design/fetch_imem.sv ====
`timescale 1ns/1ns

module fetch_imem (
    // Clock and reset
    input  logic                 i_clk,
    input  logic                 i_rst_n,

    // Strobes from the controller
    input  logic                 i_kill,
    input  logic                 i_hold,

    // From F1
    input  fetch_pkg::f1_to_f2_s i_f1_to_f2,

    // To decode
    output fetch_pkg::f2_to_d_s  o_f2_to_d
);

    import fetch_pkg::*;

    // Instruction memory, stands in for a cache
    logic [31:0] imem [IMEM_WORDS];

    logic [IMEM_IDX_WIDTH-1:0] rd_idx; // Wraps at memory size
    logic [31:0]               rd_word;

    logic     out_valid_q;
    pc_word_t out_pc_q;
    instr_t   out_instr_q;

    // Preloaded test program
    initial begin
        $readmemh(IMEM_FILE, imem);
    end

    // Word pc already lacks the byte offset bits
    assign rd_idx  = i_f1_to_f2.pc_word[IMEM_IDX_WIDTH-1:0];
    assign rd_word = imem[rd_idx];

    // Valid bit is the only control state here
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            out_valid_q <= 1'b0;
        end else if (!i_hold) begin
            if (i_kill) begin
                out_valid_q <= 1'b0; // Item in F1 is from the wrong path
            end else begin
                out_valid_q <= i_f1_to_f2.valid;
            end
        end
    end

    // Registered read plus pc, one cycle latency
    always_ff @(posedge i_clk) begin
        if (!i_hold) begin
            out_pc_q    <= i_f1_to_f2.pc_word;
            out_instr_q <= rd_word[31:2]; // Bits 1:0 always 11
        end
    end

    assign o_f2_to_d = '{valid: out_valid_q, pc_word: out_pc_q, instr: out_instr_q};

endmodule : fetch_imem

// ==== design/fetch_pc_gen.sv ====
`timescale 1ns/1ns

module fetch_pc_gen (
    // Clock and reset
    input  logic                 i_clk,
    input  logic                 i_rst_n,

    // Strobes from the controller
    input  logic                 i_issue,
    input  logic                 i_load,
    input  logic                 i_hold,

    // Redirect target, used on load
    input  fetch_pkg::pc_word_t  i_target,

    // To F2
    output fetch_pkg::f1_to_f2_s o_f1_to_f2
);

    import fetch_pkg::*;

    pc_word_t pc_q;     // Next unissued word pc
    pc_word_t pc_d;
    pc_word_t issue_pc; // Word pc sent to F2 this cycle

    logic     f1_valid_q;
    pc_word_t f1_pc_q;

    // Target replaces the counter on a flush
    assign issue_pc = i_load ? i_target : pc_q;

    // Counter advance
    always_comb begin
        pc_d = pc_q;
        if (i_load) begin
            if (i_issue) begin
                pc_d = i_target + pc_word_t'(1); // Target goes out now
            end else begin
                pc_d = i_target;                 // Target waits for RUN
            end
        end else if (i_issue) begin
            pc_d = pc_q + pc_word_t'(1);
        end
    end

    // Control state of F1
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc_q       <= RESET_PC_WORD;
            f1_valid_q <= 1'b0;
        end else if (!i_hold) begin
            pc_q       <= pc_d;
            f1_valid_q <= i_issue; // Covers load while running too
        end
    end

    // Payload, no reset
    always_ff @(posedge i_clk) begin
        if (!i_hold) begin
            f1_pc_q <= issue_pc;
        end
    end

    assign o_f1_to_f2 = '{valid: f1_valid_q, pc_word: f1_pc_q};

endmodule : fetch_pc_gen

// ==== design/fetch_pkg.sv ====
package fetch_pkg;

    // Address widths
    localparam int PC_WIDTH      = 32;           // Byte address
    localparam int PC_WORD_WIDTH = PC_WIDTH - 2; // Word address, low two bits implied

    // Instruction memory
    localparam int    IMEM_WORDS     = 32;
    localparam int    IMEM_IDX_WIDTH = $clog2(IMEM_WORDS); // Low word pc bits, wraps
    localparam string IMEM_FILE      = "test/imem.hex";

    // Fetch starts here after reset
    localparam logic [PC_WORD_WIDTH-1:0] RESET_PC_WORD = '0;

    typedef logic [PC_WORD_WIDTH-1:0] pc_word_t;

    // Low two bits are always 11 without compressed support
    typedef logic [31:2] instr_t;

    // F1 to F2 stage register
    typedef struct packed {
        logic     valid;
        pc_word_t pc_word;
    } f1_to_f2_s;

    // F2 to decode stage register
    typedef struct packed {
        logic     valid;
        pc_word_t pc_word;
        instr_t   instr;
    } f2_to_d_s;

    // Flush pulse from execute with its new fetch target
    typedef struct packed {
        logic     flush;
        pc_word_t target;
    } redirect_s;

    // Fetch controller states
    typedef enum logic [1:0] {
        IDLE = 2'd0, // Out of reset, nothing issued yet
        RUN  = 2'd1, // One fetch per cycle
        HALT = 2'd2  // Enable dropped, pipe drains
    } fetch_state_e;

endpackage : fetch_pkg

// ==== design/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top (
    // Clock and reset
    input  logic                 i_clk,
    input  logic                 i_rst_n,

    // Control levels
    input  logic                 i_fetch_en,
    input  logic                 i_stall,    // From decode and later
    input  fetch_pkg::redirect_s i_redirect, // From execute

    // To decode
    output fetch_pkg::f2_to_d_s  o_f2_to_d
);

    import fetch_pkg::*;

    // Controller strobes
    logic issue;
    logic load;
    logic kill;
    logic hold;

    // F1 stage register
    f1_to_f2_s f1_to_f2;

    // Stall and flush decided here only
    fetch_ctrl ctrl_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_fetch_en (i_fetch_en),
        .i_stall    (i_stall),
        .i_redirect (i_redirect),
        .o_issue    (issue),
        .o_load     (load),
        .o_kill     (kill),
        .o_hold     (hold)
    );

    // F1, pc generation
    fetch_pc_gen pc_gen_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_issue    (issue),
        .i_load     (load),
        .i_hold     (hold),
        .i_target   (i_redirect.target),
        .o_f1_to_f2 (f1_to_f2)
    );

    // F2, memory read
    fetch_imem imem_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_kill     (kill),
        .i_hold     (hold),
        .i_f1_to_f2 (f1_to_f2),
        .o_f2_to_d  (o_f2_to_d)
    );

endmodule : fetch_top

// ==== src.f ====
design/fetch_pkg.sv
design/fetch_ctrl.sv
design/fetch_pc_gen.sv
design/fetch_imem.sv
design/fetch_top.sv
test/fetch_tb.sv

// ==== test/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb;

    import fetch_pkg::*;

    // DUT inputs and output
    logic      clk;
    logic      rst_n;
    logic      fetch_en;
    logic      stall;
    redirect_s redirect;
    f2_to_d_s  dout;

    // Own copy of the program
    logic [31:0] ref_mem [IMEM_WORDS];

    logic [31:0] lfsr = 32'h9a59cdc9; // Random bit source

    // Cycle model of the front end updated at each rising edge
    fetch_state_e m_state;
    pc_word_t     m_pc;     // Next unissued pc
    logic         m_f1_v;
    pc_word_t     m_f1_pc;
    logic         m_out_v;
    pc_word_t     m_out_pc;

    // What happened at the last edge
    logic     last_rst;
    logic     last_stall;
    logic     last_flush;
    pc_word_t last_target;

    // Stream rule state
    pc_word_t stream_next;
    f2_to_d_s prev_out;

    int mismatches = 0;
    int timeouts   = 0;
    int checks     = 0;
    int delivered  = 0;

    fetch_top dut_i (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_fetch_en (fetch_en),
        .i_stall    (stall),
        .i_redirect (redirect),
        .o_f2_to_d  (dout)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected decode word for a pc with the memory wrapping at its depth
    function automatic instr_t expected_instr(input pc_word_t pc);
        return ref_mem[pc % IMEM_WORDS][31:2];
    endfunction

    // Galois step with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]}; // One step per bit
        end
    endtask

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    // Inputs change 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic step_cycles(input int n);
        repeat (n) tick();
    endtask

    // One-cycle flush pulse
    task automatic flush_to(input pc_word_t target);
        redirect = '{flush: 1'b1, target: target};
        tick();
        redirect = '0;
    endtask

    task automatic wait_for_valid(input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (dout.valid !== level && cycles < limit) begin
            tick();
            cycles++;
        end
        if (dout.valid !== level) begin
            timeouts++;
            $display("Timeout at %0t ns: %s did not happen within %0d cycles", $time, what, limit);
        end
    endtask

    // Enable mostly high with stall one cycle in four and flush only when not stalled
    task automatic drive_random();
        logic [31:0] bits;
        draw_bits(3, bits);
        fetch_en = (bits != 0);
        draw_bits(2, bits);
        stall    = (bits == 0);
        redirect = '0;
        if (!stall) begin
            draw_bits(4, bits);
            if (bits == 0) begin
                draw_bits(1, bits);
                if (bits[0]) begin
                    draw_bits(6, bits); // Near the wrap point
                end else begin
                    draw_bits(30, bits);
                end
                redirect = '{flush: 1'b1, target: pc_word_t'(bits)};
            end
        end
    endtask

    // Expected pipeline contents after each edge
    always @(posedge clk) begin : model_step
        logic run;
        run         = (m_state == RUN);
        last_rst    = !rst_n;
        last_stall  = stall;
        last_flush  = redirect.flush;
        last_target = redirect.target;
        if (!rst_n) begin
            m_state = IDLE;
            m_pc    = RESET_PC_WORD;
            m_f1_v  = 1'b0;
            m_out_v = 1'b0;
        end else if (!stall) begin
            m_out_v  = redirect.flush ? 1'b0 : m_f1_v; // F1 item killed on flush
            m_out_pc = m_f1_pc;
            m_f1_v   = run;
            if (redirect.flush) begin
                m_f1_pc = redirect.target;
                m_pc    = run ? redirect.target + pc_word_t'(1) : redirect.target;
            end else if (run) begin
                m_f1_pc = m_pc;
                m_pc    = m_pc + pc_word_t'(1);
            end
            case (m_state)
                IDLE:    m_state = fetch_en ? RUN : IDLE;
                RUN:     m_state = fetch_en ? RUN : HALT;
                default: m_state = fetch_en ? RUN : HALT;
            endcase
        end
    end

    // Compare at the falling edge when outputs are settled
    always @(negedge clk) begin
        if (dout.valid !== m_out_v) begin
            report_mismatch($sformatf("output valid %b, expected %b", dout.valid, m_out_v));
        end else if (m_out_v) begin
            checks++;
            if (dout.pc_word !== m_out_pc) begin
                report_mismatch($sformatf("output pc %h, expected %h", dout.pc_word, m_out_pc));
            end
            if (dout.instr !== expected_instr(m_out_pc)) begin
                report_mismatch($sformatf("instr %h at pc %h, expected %h",
                                          dout.instr, m_out_pc, expected_instr(m_out_pc)));
            end
        end
        // Output frozen on a stalled edge
        if (!last_rst && last_stall && dout !== prev_out) begin
            report_mismatch("output changed on a stalled edge");
        end
        // Each new item follows the previous one or the flush target
        if (last_rst) begin
            stream_next = RESET_PC_WORD;
        end else if (!last_stall && dout.valid === 1'b1) begin
            if (dout.pc_word !== stream_next) begin
                report_mismatch($sformatf("stream pc %h, expected %h", dout.pc_word, stream_next));
            end
            stream_next = dout.pc_word + pc_word_t'(1);
            delivered++;
        end
        if (!last_rst && last_flush) begin
            stream_next = last_target;
        end
        prev_out = dout;
    end

    initial begin
        rst_n    = 1'b0;
        fetch_en = 1'b0;
        stall    = 1'b0;
        redirect = '0;
        $readmemh(IMEM_FILE, ref_mem);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            if (ref_mem[i][1:0] !== 2'b11) begin
                mismatches++;
                $display("Program word %0d is not a full-size instruction", i);
            end
        end

        step_cycles(3); // Reset for 3 cycles
        rst_n = 1'b1;

        // Nothing comes out in IDLE
        repeat (4) begin
            tick();
            if (dout.valid !== 1'b0) begin
                report_mismatch("valid output while idle");
            end
        end

        // First item two edges after enable is sampled
        fetch_en = 1'b1;
        tick(); // Edge E
        if (dout.valid !== 1'b0) begin
            report_mismatch("valid output at the edge that starts fetching");
        end
        tick(); // E+1 with the item in F1
        if (dout.valid !== 1'b0) begin
            report_mismatch("valid output one edge after start");
        end
        tick(); // E+2
        if (dout.valid !== 1'b1 || dout.pc_word !== RESET_PC_WORD
                || dout.instr !== expected_instr(RESET_PC_WORD)) begin
            report_mismatch("first item is not the reset pc with its instruction");
        end

        step_cycles(40); // Past the memory wrap

        // Stall in the middle of the stream
        stall = 1'b1;
        step_cycles(4);
        stall = 1'b0;
        step_cycles(3);

        // Flush across the wrap and then a plain one
        flush_to(pc_word_t'(29));
        step_cycles(8);
        flush_to(pc_word_t'(5));
        stall = 1'b1; // Stall right after the flush
        step_cycles(2);
        stall = 1'b0;
        step_cycles(6);

        // Drain and resume
        fetch_en = 1'b0;
        wait_for_valid(1'b0, 8, "drain after enable dropped");
        repeat (5) begin
            tick();
            if (dout.valid !== 1'b0) begin
                report_mismatch("valid output while halted");
            end
        end
        fetch_en = 1'b1;
        wait_for_valid(1'b1, 8, "resume after enable raised");
        step_cycles(5);

        // Flush while halted only moves the pc
        fetch_en = 1'b0;
        wait_for_valid(1'b0, 8, "drain before halted flush");
        flush_to(pc_word_t'(12));
        step_cycles(2);
        fetch_en = 1'b1;
        wait_for_valid(1'b1, 8, "resume after halted flush");
        step_cycles(4);

        // Random mix
        repeat (3000) begin
            drive_random();
            tick();
        end
        fetch_en = 1'b1;
        stall    = 1'b0;
        redirect = '0;
        step_cycles(4);

        $display("Run complete: %0d mismatches, %0d timeouts, %0d output checks, %0d items",
                 mismatches, timeouts, checks, delivered);
        if (mismatches == 0 && timeouts == 0 && checks > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : fetch_tb

// ==== test/imem.hex ====
// One 32-bit instruction word per line, word index 0 to 31 in order
// Word N holds addi xN, x0, N so every index reads back differently
00000013
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793
01000813
01100893
01200913
01300993
01400a13
01500a93
01600b13
01700b93
01800c13
01900c93
01a00d13
01b00d93
01c00e13
01d00e93
01e00f13
01f00f93
